//--- common/ulaPkg.sv
package ulaPkg;

   ////////////////////
   // Bus and video types
   ////////////////////

   // Current tick position in the frame
   typedef struct packed {
      // Horizontal tick, 0 to 447
      logic [8:0] hc;
      // Line number, 0 to 311
      logic [8:0] vc;
   } rasterT;

   // CPU side of the bus
   typedef struct packed {
      logic [15:0] addr;
      logic        iorqN;
      logic        rdN;
      logic        wrN;
      logic [7:0]  data;
   } cpuBusT;

   // One attribute byte as stored in VRAM
   typedef struct packed {
      logic       flash;
      logic       bright;
      logic [2:0] paper;
      logic [2:0] ink;
   } attrT;

   // Output colour, GGGRRRBBB
   typedef struct packed {
      logic [2:0] g;
      logic [2:0] r;
      logic [2:0] b;
   } rgb9T;

   // Per-tick strobes from the fetch sequencer
   typedef struct packed {
      logic bitmapLoad;
      logic attrLoad;
      logic serializerLoad;
      logic attrOutputLoad;
      logic videoEnable;
   } fetchCtlT;

   ////////////////////
   // Constants
   ////////////////////

   // Paper window in ticks and lines
   localparam logic [8:0] PaperLeft   = 9'd0;
   localparam logic [8:0] PaperRight  = 9'd255;
   localparam logic [8:0] PaperTop    = 9'd0;
   localparam logic [8:0] PaperBottom = 9'd191;

   // Channel levels
   localparam logic [2:0] LevelNone = 3'd0;
   localparam logic [2:0] LevelHalf = 3'd5;
   localparam logic [2:0] LevelFull = 3'd7;

   // Red border out of reset
   localparam logic [2:0] BorderReset = 3'd2;

   // Attribute area starts right after the 6 KB bitmap
   localparam logic [13:0] AttrBase = 14'd6144;

   // Value seen by the CPU when nothing drives the bus
   localparam logic [7:0] IdleBus = 8'hFF;

endpackage

//--- hw/rasterCounter.sv
module rasterCounter #(
   parameter int LinePixels = 448,
   parameter int FrameLines = 312,
   parameter int IntLine    = 248
) (
   input  logic           clk7,
   input  logic           rst_n,
   output ulaPkg::rasterT raster,
   output logic           intN
);
   import ulaPkg::*;

   rasterT pos;
   logic   lineEnd;
   logic   frameEnd;

   // Wrap points
   assign lineEnd  = pos.hc == 9'(LinePixels - 1);
   assign frameEnd = pos.vc == 9'(FrameLines - 1);

   ////////////////////
   // Tick counters
   ////////////////////
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         pos <= '0;
      end else if (lineEnd) begin
         pos.hc <= '0;
         // Next line, or back to the top
         pos.vc <= frameEnd ? 9'd0 : pos.vc + 9'd1;
      end else begin
         pos.hc <= pos.hc + 9'd1;
      end
   end

   assign raster = pos;

   // Frame interrupt, 64 ticks wide on the interrupt line
   assign intN = !(pos.vc == 9'(IntLine) && pos.hc >= 9'd2 && pos.hc <= 9'd65);

endmodule

//--- video/fetchControl.sv
module fetchControl (
   input  logic             clk7,
   input  ulaPkg::rasterT   raster,
   output ulaPkg::fetchCtlT fetchCtl,
   output logic [13:0]      va
);
   import ulaPkg::*;

   logic [4:0] columnAddr;
   logic [3:0] phase;
   logic       paperLine;
   logic       fetchArea;
   logic       attrAddr;

   // Position inside the 16-tick fetch group
   assign phase = raster.hc[3:0];

   // Lines that carry paper
   assign paperLine = raster.vc >= PaperTop && raster.vc <= PaperBottom;

   // Fetches run over the unshifted paper columns
   assign fetchArea = paperLine && raster.hc >= PaperLeft && raster.hc <= PaperRight;

   ////////////////////
   // Strobe decode
   ////////////////////
   always_comb begin
      fetchCtl = '0;
      attrAddr = 1'b0;
      // Output attribute moves every 8 ticks, border or paper
      fetchCtl.attrOutputLoad = raster.hc[2:0] == 3'd4;
      // Display window trails the fetch window by 8 ticks
      fetchCtl.videoEnable = paperLine &&
                             raster.hc >= PaperLeft + 9'd8 &&
                             raster.hc <= PaperRight + 9'd8;
      fetchCtl.serializerLoad = fetchCtl.videoEnable && raster.hc[2:0] == 3'd4;
      if (fetchArea) begin
         case (phase)
            // Bitmap bytes, address already out on 8 and 12
            4'd9, 4'd13: begin
               fetchCtl.bitmapLoad = 1'b1;
            end
            // Attribute address phase
            4'd10, 4'd14: begin
               attrAddr = 1'b1;
            end
            // Attribute bytes
            4'd11, 4'd15: begin
               attrAddr = 1'b1;
               fetchCtl.attrLoad = 1'b1;
            end
            default: begin
               attrAddr = 1'b0;
            end
         endcase
      end
   end

   // Column register, next character column
   always_ff @(posedge clk7) begin
      if (raster.hc[2:0] == 3'd3) begin
         columnAddr <= raster.hc[7:3];
      end
   end

   ////////////////////
   // VRAM address
   ////////////////////
   // Bitmap layout is third, pixel row, char row, column
   // Attribute is one byte per 8x8 cell after the bitmap
   assign va = attrAddr ? (AttrBase | {4'b0000, raster.vc[7:3], columnAddr})
                        : {1'b0, raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], columnAddr};

endmodule

//--- video/pixelShifter.sv
module pixelShifter #(
   parameter int IntLine = 248
) (
   input  logic             clk7,
   input  logic             rst_n,
   input  ulaPkg::rasterT   raster,
   input  ulaPkg::fetchCtlT fetchCtl,
   input  logic [7:0]       vramData,
   output logic             pixel,
   output ulaPkg::attrT     attrData
);
   import ulaPkg::*;

   logic [7:0] bitmapData;
   logic [7:0] serializer;
   logic [4:0] flashCounter;
   logic       flashLatched;
   logic       flashPhase;

   ////////////////////
   // VRAM data registers
   ////////////////////
   // Bitmap byte of the current column
   always_ff @(posedge clk7) begin
      if (fetchCtl.bitmapLoad) begin
         bitmapData <= vramData;
      end
   end

   // Attribute byte, handed on to the colour stage
   always_ff @(posedge clk7) begin
      if (fetchCtl.attrLoad) begin
         attrData <= attrT'(vramData);
      end
   end

   ////////////////////
   // Serializer
   ////////////////////
   // MSB first, zeros shift in behind the byte
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         serializer <= '0;
      end else if (fetchCtl.serializerLoad) begin
         serializer <= bitmapData;
      end else begin
         serializer <= {serializer[6:0], 1'b0};
      end
   end

   // Flash bit of the cell now being shown
   // Border cells never flash
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashLatched <= 1'b0;
      end else if (fetchCtl.attrOutputLoad) begin
         flashLatched <= fetchCtl.videoEnable && attrData.flash;
      end
   end

   // Once per frame on the interrupt line
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         flashCounter <= '0;
      end else if (raster.vc == 9'(IntLine) && raster.hc == 9'd0) begin
         flashCounter <= flashCounter + 5'd1;
      end
   end

   // Toggles every 16 frames
   assign flashPhase = flashCounter[4];

   // Ink and paper swap while flashing
   assign pixel = serializer[7] ^ (flashLatched & flashPhase);

endmodule

//--- video/colourMapper.sv
module colourMapper (
   input  logic             clk7,
   input  ulaPkg::fetchCtlT fetchCtl,
   input  ulaPkg::attrT     attrData,
   input  logic [2:0]       border,
   input  logic             pixel,
   output ulaPkg::rgb9T     rgb
);
   import ulaPkg::*;

   attrT       nextAttr;
   attrT       attrOut;
   logic [2:0] colour;
   logic [2:0] onLevel;

   ////////////////////
   // Attribute output register
   ////////////////////
   // Outside the display window the border acts as paper
   always_comb begin
      if (fetchCtl.videoEnable) begin
         nextAttr = attrData;
      end else begin
         nextAttr       = '0;
         nextAttr.paper = border;
      end
   end

   // Holds for the 8 pixels of one cell
   always_ff @(posedge clk7) begin
      if (fetchCtl.attrOutputLoad) begin
         attrOut <= nextAttr;
      end
   end

   ////////////////////
   // IGRB to GRB
   ////////////////////
   // Ink on a set pixel, paper otherwise
   assign colour = pixel ? attrOut.ink : attrOut.paper;

   // Bright lifts every lit channel to full
   assign onLevel = attrOut.bright ? LevelFull : LevelHalf;

   // Colour bits are G, R, B from MSB down
   // Unlit channels stay dark, so black ignores bright
   assign rgb.g = colour[2] ? onLevel : LevelNone;
   assign rgb.r = colour[1] ? onLevel : LevelNone;
   assign rgb.b = colour[0] ? onLevel : LevelNone;

endmodule

//--- hw/ioPorts.sv
module ioPorts (
   input  logic           clk7,
   input  logic           rst_n,
   input  ulaPkg::cpuBusT cpuBus,
   input  logic [4:0]     kbd,
   input  logic           ear,
   input  logic           issue2Keyboard,
   output logic [2:0]     border,
   output logic           spk,
   output logic           mic,
   output logic [7:0]     dout
);
   import ulaPkg::*;

   logic feWrite;
   logic feRead;
   logic mixedEar;

   ////////////////////
   // Port decode
   ////////////////////
   // ULA answers any even port
   assign feWrite = !cpuBus.iorqN && !cpuBus.wrN && !cpuBus.addr[0];
   assign feRead  = !cpuBus.iorqN && !cpuBus.rdN && !cpuBus.addr[0];

   ////////////////////
   // Port FE registers
   ////////////////////
   always_ff @(posedge clk7) begin
      if (!rst_n) begin
         border <= BorderReset;
         spk    <= 1'b0;
         mic    <= 1'b0;
      end else if (feWrite) begin
         // Data bits 2:0 border, 3 mic, 4 speaker
         border <= cpuBus.data[2:0];
         mic    <= cpuBus.data[3];
         spk    <= cpuBus.data[4];
      end
   end

   // EAR as the CPU sees it
   // Issue 2 boards also leak MIC onto the input
   always_comb begin
      if (issue2Keyboard) begin
         mixedEar = ear ^ (spk | mic);
      end else begin
         mixedEar = ear ^ spk;
      end
   end

   ////////////////////
   // CPU read mux
   ////////////////////
   always_comb begin
      if (feRead) begin
         // Bits 7 and 5 float high
         dout = {1'b1, mixedEar, 1'b1, kbd};
      end else begin
         dout = IdleBus;
      end
   end

endmodule

//--- hw/ulaTop.sv
module ulaTop #(
   parameter int LinePixels = 448,
   parameter int FrameLines = 312,
   parameter int IntLine    = 248
) (
   input  logic           clk7,
   input  logic           rst_n,
   input  ulaPkg::cpuBusT cpuBus,
   output logic [7:0]     dout,
   output logic           intN,
   output logic [13:0]    va,
   input  logic [7:0]     vramData,
   input  logic [4:0]     kbd,
   input  logic           ear,
   input  logic           issue2Keyboard,
   output logic           spk,
   output logic           mic,
   output ulaPkg::rgb9T   rgb
);
   import ulaPkg::*;

   rasterT     raster;
   fetchCtlT   fetchCtl;
   attrT       attrData;
   logic       pixel;
   logic [2:0] border;

   ////////////////////
   // Timing
   ////////////////////
   rasterCounter #(
      .LinePixels(LinePixels),
      .FrameLines(FrameLines),
      .IntLine   (IntLine)
   ) uRaster (
      .clk7  (clk7),
      .rst_n (rst_n),
      .raster(raster),
      .intN  (intN)
   );

   ////////////////////
   // Video path
   ////////////////////
   // Address and strobes
   fetchControl uFetch (
      .clk7    (clk7),
      .raster  (raster),
      .fetchCtl(fetchCtl),
      .va      (va)
   );

   // Bytes in, one pixel per tick out
   pixelShifter #(
      .IntLine(IntLine)
   ) uShifter (
      .clk7    (clk7),
      .rst_n   (rst_n),
      .raster  (raster),
      .fetchCtl(fetchCtl),
      .vramData(vramData),
      .pixel   (pixel),
      .attrData(attrData)
   );

   colourMapper uColour (
      .clk7    (clk7),
      .fetchCtl(fetchCtl),
      .attrData(attrData),
      .border  (border),
      .pixel   (pixel),
      .rgb     (rgb)
   );

   ////////////////////
   // CPU ports
   ////////////////////
   ioPorts uPorts (
      .clk7          (clk7),
      .rst_n         (rst_n),
      .cpuBus        (cpuBus),
      .kbd           (kbd),
      .ear           (ear),
      .issue2Keyboard(issue2Keyboard),
      .border        (border),
      .spk           (spk),
      .mic           (mic),
      .dout          (dout)
   );

endmodule

//--- verif/tbChecker.sv
module tbChecker #(
   parameter int LinePixels = 448,
   parameter int FrameLines = 312,
   parameter int IntLine    = 248
) (
   input  logic           clk7,
   input  logic           rst_n,
   input  ulaPkg::cpuBusT cpuBus,
   input  logic [4:0]     kbd,
   input  logic           ear,
   input  logic           issue2Keyboard,
   input  logic [7:0]     dout,
   input  logic           intN,
   input  logic [13:0]    va,
   input  logic           spk,
   input  logic           mic,
   input  ulaPkg::rgb9T   rgb,
   input  logic           runDone,
   output int             errorCount,
   output logic           reported
);
   import ulaPkg::*;

   // Fetch and shift delay from screen column to rgb
   localparam int PixelDelay = 13;
   localparam int MaxShown   = 100;

   // Loaded by the testbench top before reset ends
   logic [7:0] vramCopy [0:16383];

   // Model state
   int         hc = 0;
   int         vc = 0;
   logic [2:0] borderReg = BorderReset;
   logic       spkReg = 1'b0;
   logic       micReg = 1'b0;
   logic [4:0] flashCount = '0;
   logic [2:0] shownBorder = BorderReset;
   logic       shownValid = 1'b0;
   logic [4:0] columnReg = '0;
   logic       columnValid = 1'b0;
   logic       active = 1'b0;

   // Counts for the closing line
   int   errors = 0;
   int   checks = 0;
   int   pixelChecks = 0;
   int   flashSwaps = 0;
   int   portWrites = 0;
   int   intPulses = 0;
   logic doneFlag = 1'b0;

   assign errorCount = errors;
   assign reported   = doneFlag;

   ////////////////////
   // Reference helpers
   ////////////////////
   task automatic flagMismatch(input string what, input logic [15:0] got,
                               input logic [15:0] want);
      errors++;
      if (errors <= MaxShown) begin
         $display("error %0t: %s got %0h expected %0h at hc %0d vc %0d",
                  $time, what, got, want, hc, vc);
      end else if (errors == MaxShown + 1) begin
         $display("Further mismatch lines are not shown");
      end
   endtask

   // Each lit channel at half or full level
   // G from bit 2 and B from bit 0
   function automatic rgb9T levelMap(input logic [2:0] colour, input logic bright);
      logic [2:0] lit;
      rgb9T       c;
      lit = bright ? LevelFull : LevelHalf;
      c.g = colour[2] ? lit : LevelNone;
      c.r = colour[1] ? lit : LevelNone;
      c.b = colour[0] ? lit : LevelNone;
      return c;
   endfunction

   // Thirds of 64 lines, then pixel row, then character row
   function automatic int bitmapAddress(input int y, input int column);
      return 2048 * (y / 64) + 256 * (y % 8) + 32 * ((y / 8) % 8) + column;
   endfunction

   // One attribute byte per 8x8 cell after the bitmap
   function automatic int attrAddress(input int y, input int column);
      return int'(AttrBase) + 32 * (y / 8) + column;
   endfunction

   // Expected colour of screen pixel (x, y)
   function automatic rgb9T paperColour(input int x, input int y, output logic swapped);
      logic [7:0] attr;
      logic       ink;
      attr    = vramCopy[attrAddress(y, x / 8)];
      ink     = vramCopy[bitmapAddress(y, x / 8)][7 - x % 8];
      swapped = attr[7] && flashCount[4];
      ink     = ink ^ swapped;
      return ink ? levelMap(attr[2:0], attr[6]) : levelMap(attr[5:3], attr[6]);
   endfunction

   // Expected dout of the current bus cycle
   function automatic logic [7:0] portRead();
      logic earBit;
      if (!cpuBus.iorqN && !cpuBus.rdN && !cpuBus.addr[0]) begin
         earBit = issue2Keyboard ? ear ^ (spkReg | micReg) : ear ^ spkReg;
         return {1'b1, earBit, 1'b1, kbd};
      end
      return 8'hFF;
   endfunction

   ////////////////////
   // Compare and advance the model
   ////////////////////
   always @(posedge clk7) begin
      rgb9T        wantRgb;
      logic [7:0]  wantDout;
      logic [13:0] wantVa;
      logic        wantInt;
      logic        swapped;
      if (!rst_n) begin
         hc          = 0;
         vc          = 0;
         borderReg   = BorderReset;
         spkReg      = 1'b0;
         micReg      = 1'b0;
         flashCount  = '0;
         shownValid  = 1'b0;
         columnValid = 1'b0;
         active      = 1'b1;
      end else if (active) begin
         // 64-tick interrupt window
         wantInt = !(vc == IntLine && hc >= 2 && hc <= 65);
         if (intN !== wantInt) flagMismatch("intN", 16'(intN), 16'(wantInt));
         if (vc == IntLine && hc == 2) intPulses++;
         if (spk !== spkReg) flagMismatch("spk", 16'(spk), 16'(spkReg));
         if (mic !== micReg) flagMismatch("mic", 16'(mic), 16'(micReg));
         wantDout = portRead();
         if (dout !== wantDout) flagMismatch("dout", 16'(dout), 16'(wantDout));
         checks += 4;
         // VRAM address on paper lines
         if (columnValid && vc <= int'(PaperBottom)) begin
            if (hc <= int'(PaperRight) && (hc % 16) inside {10, 11, 14, 15}) begin
               wantVa = 14'(attrAddress(vc, int'(columnReg)));
            end else begin
               wantVa = 14'(bitmapAddress(vc, int'(columnReg)));
            end
            if (va !== wantVa) flagMismatch("va", 16'(va), 16'(wantVa));
            checks++;
         end
         // Paper pixel or border
         if (vc <= int'(PaperBottom) && hc >= int'(PaperLeft) + PixelDelay &&
             hc <= int'(PaperRight) + PixelDelay) begin
            wantRgb = paperColour(hc - PixelDelay, vc, swapped);
            if (swapped) flashSwaps++;
            pixelChecks++;
         end else begin
            wantRgb = levelMap(shownBorder, 1'b0);
         end
         if (shownValid) begin
            if (rgb !== wantRgb) flagMismatch("rgb", 16'(rgb), 16'(wantRgb));
            checks++;
         end
         // Border latched at the cell boundary keeps the old value on a write
         if (hc % 8 == 4) begin
            shownBorder = borderReg;
            shownValid  = 1'b1;
         end
         // Column register follows hc bits 7:3
         if (hc % 8 == 3) begin
            columnReg   = 5'(hc / 8);
            columnValid = 1'b1;
         end
         if (!cpuBus.iorqN && !cpuBus.wrN && !cpuBus.addr[0]) begin
            borderReg = cpuBus.data[2:0];
            micReg    = cpuBus.data[3];
            spkReg    = cpuBus.data[4];
            portWrites++;
         end
         if (hc == 0 && vc == IntLine) flashCount = flashCount + 5'd1;
         // Raster position
         if (hc == LinePixels - 1) begin
            hc = 0;
            vc = vc == FrameLines - 1 ? 0 : vc + 1;
         end else begin
            hc++;
         end
      end
      if (runDone && !doneFlag) begin
         if (flashSwaps == 0) begin
            $display("No flashing paper pixel was seen while the flash phase was set");
            errors++;
         end
         if (portWrites == 0) begin
            $display("No port FE write was seen during the run");
            errors++;
         end
         $display(
            "checks %0d, pixels %0d, flash swaps %0d, port writes %0d, interrupts %0d, errors %0d",
            checks, pixelChecks, flashSwaps, portWrites, intPulses, errors);
         doneFlag = 1'b1;
      end
   end

endmodule

//--- verif/tbTop.sv
module tbTop;
   import ulaPkg::*;

   localparam int LinePixels    = 448;
   localparam int FrameLines    = 312;
   localparam int IntLine       = 248;
   localparam int RunFrames     = 34;
   localparam int FrameCycles   = LinePixels * FrameLines;
   // Two frames of slack over the run
   localparam int TimeoutCycles = (RunFrames + 2) * FrameCycles;
   localparam int VramBytes     = 16384;
   localparam int AttrBytes     = 768;

   logic        clk7;
   logic        rst_n;
   cpuBusT      cpuBus;
   logic [7:0]  dout;
   logic        intN;
   logic [13:0] va;
   logic [7:0]  vramData;
   logic [4:0]  kbd;
   logic        ear;
   logic        issue2Keyboard;
   logic        spk;
   logic        mic;
   rgb9T        rgb;
   logic        runDone;
   int          errorCount;
   logic        reported;
   int unsigned seed;
   int          cycles = 0;
   int          frames = 0;
   logic        prevIntN = 1'b1;

   // 16 KB video RAM answering in the same cycle
   logic [7:0] vram [0:VramBytes-1];
   assign vramData = vram[va];

   ulaTop #(
      .LinePixels(LinePixels),
      .FrameLines(FrameLines),
      .IntLine   (IntLine)
   ) u_dut (
      .clk7          (clk7),
      .rst_n         (rst_n),
      .cpuBus        (cpuBus),
      .dout          (dout),
      .intN          (intN),
      .va            (va),
      .vramData      (vramData),
      .kbd           (kbd),
      .ear           (ear),
      .issue2Keyboard(issue2Keyboard),
      .spk           (spk),
      .mic           (mic),
      .rgb           (rgb)
   );

   tbChecker #(
      .LinePixels(LinePixels),
      .FrameLines(FrameLines),
      .IntLine   (IntLine)
   ) uCheck (
      .clk7          (clk7),
      .rst_n         (rst_n),
      .cpuBus        (cpuBus),
      .kbd           (kbd),
      .ear           (ear),
      .issue2Keyboard(issue2Keyboard),
      .dout          (dout),
      .intN          (intN),
      .va            (va),
      .spk           (spk),
      .mic           (mic),
      .rgb           (rgb),
      .runDone       (runDone),
      .errorCount    (errorCount),
      .reported      (reported)
   );

   ////////////////////
   // Clock and watchdog
   ////////////////////
   initial begin
      clk7 = 1'b0;
      forever #2 clk7 = ~clk7;
   end

   // Frames counted on each falling edge of intN
   always @(posedge clk7) begin
      cycles <= cycles + 1;
      if (rst_n && prevIntN && !intN) begin
         frames <= frames + 1;
      end
      prevIntN <= intN;
      if (cycles >= TimeoutCycles) begin
         $display("Timeout: run did not finish within %0d clock cycles", TimeoutCycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   ////////////////////
   // Bus stimulus
   ////////////////////
   // No I/O and no memory access
   task automatic busIdle();
      cpuBus.addr  = 16'hFFFF;
      cpuBus.iorqN = 1'b1;
      cpuBus.rdN   = 1'b1;
      cpuBus.wrN   = 1'b1;
      cpuBus.data  = 8'hFF;
   endtask

   // One bus cycle picked at random and mostly idle
   task automatic driveRandomCycle();
      int unsigned pick;
      pick = $urandom % 32;
      busIdle();
      kbd  = 5'($urandom);
      ear  = 1'($urandom);
      if ($urandom % 64 == 0) begin
         issue2Keyboard = !issue2Keyboard;
      end
      cpuBus.data = 8'($urandom);
      if (pick < 2) begin
         // Port FE write
         cpuBus.addr  = {8'($urandom), 8'hFE};
         cpuBus.iorqN = 1'b0;
         cpuBus.wrN   = 1'b0;
      end else if (pick < 10) begin
         // Port FE read
         cpuBus.addr  = {8'($urandom), 8'hFE};
         cpuBus.iorqN = 1'b0;
         cpuBus.rdN   = 1'b0;
      end else if (pick < 14) begin
         // Odd port so the ULA stays off the bus
         cpuBus.addr  = 16'($urandom) | 16'h0001;
         cpuBus.iorqN = 1'b0;
         cpuBus.rdN   = pick == 13;
         cpuBus.wrN   = pick != 13;
      end else if (pick == 14) begin
         // Memory cycle with iorqN high
         cpuBus.addr = 16'($urandom);
         cpuBus.rdN  = 1'($urandom);
         cpuBus.wrN  = !cpuBus.rdN;
      end
   endtask

   // Random bytes with flash on about one attribute in four
   task automatic fillVram();
      for (int a = 0; a < VramBytes; a++) begin
         vram[a] = 8'($urandom);
         if (a >= int'(AttrBase) && a < int'(AttrBase) + AttrBytes) begin
            vram[a][7] = $urandom % 4 == 0;
         end
         uCheck.vramCopy[a] = vram[a];
      end
   endtask

   ////////////////////
   // Run
   ////////////////////
   initial begin
      seed = 32'h397e_8473;
      void'($urandom(seed));
      rst_n          = 1'b0;
      kbd            = 5'h1F;
      ear            = 1'b0;
      issue2Keyboard = 1'b0;
      runDone        = 1'b0;
      busIdle();
      fillVram();
      repeat (5) @(negedge clk7);
      rst_n = 1'b1;
      while (frames < RunFrames) begin
         @(negedge clk7);
         driveRandomCycle();
      end
      @(negedge clk7);
      busIdle();
      runDone = 1'b1;
      while (!reported) begin
         @(negedge clk7);
      end
      if (errorCount == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- files.f
common/ulaPkg.sv
hw/rasterCounter.sv
video/fetchControl.sv
video/pixelShifter.sv
video/colourMapper.sv
hw/ioPorts.sv
hw/ulaTop.sv
verif/tbChecker.sv
verif/tbTop.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tbTop
FILELIST = files.f
OBJDIR   = obj_dir
PASS     = *** TEST PASSED ***

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --Mdir $(OBJDIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS)"

clean:
	rm -rf $(OBJDIR)
